// ==== Bender.yml ====
package:
  name: spi_bridge

sources:
  - include_dirs:
      - source
    files:
      - source/spi_link_pkg.sv
      - source/mem_pkg.sv
      - source/mem_credit_if.sv
      - source/spi_shift_unit.sv
      - source/spi_frame_decoder.sv
      - source/scratch_memory.sv
      - source/spi_bridge_top.sv
      - target: test
        files:
          - testbench/tb_spi_bridge.sv

// ==== sim.f ====
+incdir+source
source/spi_link_pkg.sv
source/mem_pkg.sv
source/mem_credit_if.sv
source/spi_shift_unit.sv
source/spi_frame_decoder.sv
source/scratch_memory.sv
source/spi_bridge_top.sv
testbench/tb_spi_bridge.sv

// ==== source/mem_credit_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface mem_credit_if import mem_pkg::*; ();

   // Request side, one cycle per request
   logic      req_valid;
   logic      req_write;      // 1 store, 0 fetch
   mem_addr_t req_addr;
   mem_data_t req_wdata;

   // Read data comes back once per fetch
   logic      rsp_valid;
   mem_data_t rsp_rdata;

   // One pulse per retired request
   logic      credit_return;

   // Frame decoder side
   modport requester (
      output req_valid,
      output req_write,
      output req_addr,
      output req_wdata,
      input  rsp_valid,
      input  rsp_rdata,
      input  credit_return
   );

   // Scratch memory side
   modport responder (
      input  req_valid,
      input  req_write,
      input  req_addr,
      input  req_wdata,
      output rsp_valid,
      output rsp_rdata,
      output credit_return
   );

endinterface

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

`include "spi_bridge_config.svh"

package mem_pkg;

   // Byte address into the scratch array, wraps 255 -> 0 by width
   typedef logic [$clog2(`MEM_DEPTH)-1:0] mem_addr_t;

   // One stored word
   typedef logic [7:0] mem_data_t;

   // Holds 0 up to MEM_CREDITS inclusive
   typedef logic [$clog2(`MEM_CREDITS+1)-1:0] credit_t;

endpackage

`default_nettype wire

// ==== source/scratch_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_config.svh"

module scratch_memory import mem_pkg::*; (
   input  wire             spi_sck,
   input  wire             rst_n,
   mem_credit_if.responder mem
);

   localparam int PTR_BITS = $clog2(`MEM_CREDITS);

   // Request queue, one slot per credit
   logic      q_write [`MEM_CREDITS];
   mem_addr_t q_addr  [`MEM_CREDITS];
   mem_data_t q_wdata [`MEM_CREDITS];

   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   credit_t             count;     // Occupied slots
   logic                retire;    // Head leaves this cycle

   mem_data_t mem_array [`MEM_DEPTH];

   ////////////////////////////////////////
   // Queue
   ////////////////////////////////////////

   // One per cycle whenever anything waits
   assign retire = (count != '0);

   always_ff @(posedge spi_sck or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (mem.req_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (retire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + credit_t'(mem.req_valid) - credit_t'(retire);
      end
   end

   always_ff @(posedge spi_sck) begin
      if (mem.req_valid) begin
         q_write[wr_ptr] <= mem.req_write;
         q_addr[wr_ptr]  <= mem.req_addr;
         q_wdata[wr_ptr] <= mem.req_wdata;
      end
   end

   ////////////////////////////////////////
   // Array and response
   ////////////////////////////////////////

   always_ff @(posedge spi_sck) begin
      if (retire && q_write[rd_ptr]) begin
         mem_array[q_addr[rd_ptr]] <= q_wdata[rd_ptr];
      end
   end

   // Fetch answers in the retire cycle, along with its credit
   assign mem.rsp_valid     = retire && !q_write[rd_ptr];
   assign mem.rsp_rdata     = mem_array[q_addr[rd_ptr]];
   assign mem.credit_return = retire;   // Stores return one too

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Requester must respect its credits, full queue takes nothing
   a_queue_no_overflow: assert property (@(posedge spi_sck) disable iff (!rst_n)
      mem.req_valid |-> (count < credit_t'(`MEM_CREDITS)));

endmodule

`default_nettype wire

// ==== source/spi_bridge_config.svh ====
`ifndef SPI_BRIDGE_CONFIG_SVH
`define SPI_BRIDGE_CONFIG_SVH

////////////////////////////////////////
// Scratch memory
////////////////////////////////////////

// Bytes in the scratch array, addresses wrap at the top
`define MEM_DEPTH     256

// Request queue depth in front of the array
// Decoder starts with this many credits
`define MEM_CREDITS   4

////////////////////////////////////////
// Serial frame opcodes
////////////////////////////////////////

`define OP_WRITE      8'h02    // Store bytes from addr on
`define OP_READ       8'h03    // Dummy byte, then data out

////////////////////////////////////////
// Board indicator
////////////////////////////////////////

// Activity counter width, LED shows the top bit
`define LED_CNT_BITS  5

`endif

// ==== source/spi_bridge_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_config.svh"

module spi_bridge_top import spi_link_pkg::*; (
   input  wire        spi_sck,
   input  wire        pll_locked,
   input  wire        cs_l,
   input  wire        mosi,
   output wire        miso,
   output logic [1:0] led
);

   logic                     rst_n_r;
   logic                     rst_n;     // Internal reset, active low
   logic [`LED_CNT_BITS-1:0] led_cnt;

   byte_t rx_byte;
   logic  rx_done;
   byte_t tx_byte;
   logic  tx_load;

   ////////////////////////////////////////
   // Reset and activity LED
   ////////////////////////////////////////

   // Drops at once with the lock, leaves on the next clock
   always_ff @(posedge spi_sck or negedge pll_locked) begin
      if (!pll_locked) begin
         rst_n_r <= 1'b0;
      end else begin
         rst_n_r <= 1'b1;
      end
   end

   assign rst_n = rst_n_r;

   // Runs only between frames
   always_ff @(posedge spi_sck or negedge rst_n) begin
      if (!rst_n) begin
         led_cnt <= '0;
      end else if (cs_l) begin
         led_cnt <= led_cnt + 1'b1;
      end
   end

   assign led[0] = 1'b0;                                // Unused on the board
   assign led[1] = led_cnt[`LED_CNT_BITS-1] & cs_l;     // Blinks when idle

   ////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////

   mem_credit_if u_mem_if ();

   spi_shift_unit u_spi_shift_unit (
      .spi_sck (spi_sck),
      .rst_n   (rst_n),
      .cs_l    (cs_l),
      .mosi    (mosi),
      .miso    (miso),
      .rx_byte (rx_byte),
      .rx_done (rx_done),
      .tx_byte (tx_byte),
      .tx_load (tx_load)
   );

   spi_frame_decoder u_spi_frame_decoder (
      .spi_sck (spi_sck),
      .rst_n   (rst_n),
      .cs_l    (cs_l),
      .rx_byte (rx_byte),
      .rx_done (rx_done),
      .tx_byte (tx_byte),
      .tx_load (tx_load),
      .mem     (u_mem_if.requester)
   );

   // Contents survive reset
   scratch_memory u_scratch_memory (
      .spi_sck (spi_sck),
      .rst_n   (rst_n),
      .mem     (u_mem_if.responder)
   );

endmodule

`default_nettype wire

// ==== source/spi_frame_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_config.svh"

module spi_frame_decoder import spi_link_pkg::*, mem_pkg::*; (
   input  wire            spi_sck,
   input  wire            rst_n,
   input  wire            cs_l,
   input  wire byte_t     rx_byte,
   input  wire            rx_done,
   output byte_t          tx_byte,
   output logic           tx_load,
   mem_credit_if.requester mem
);

   frame_state_e state;
   opcode_e      op;             // Decoded in byte 0
   mem_addr_t    addr;           // Next address to store or fetch
   credit_t      credits;        // Free queue slots at the memory
   logic         req_pend;       // Request waiting for a credit
   logic         req_write_q;
   mem_addr_t    req_addr_q;
   mem_data_t    req_wdata_q;
   byte_t        rd_buf;         // Prefetched byte for the next period
   logic         rd_buf_valid;
   logic         reading;        // Dummy or read data byte in progress
   logic         new_req;        // Current byte asks for a memory access
   logic         issue;

   assign reading = (state == ST_DUMMY) || (state == ST_READ_DATA);

   // Read prefetch after the address, store per write byte, prefetch per read byte
   assign new_req = ((state == ST_ADDR) && (op == OPC_READ)) ||
                    (state == ST_WRITE_DATA) || reading;

   ////////////////////////////////////////
   // Frame FSM
   ////////////////////////////////////////

   always_ff @(posedge spi_sck or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_OPCODE;
         op    <= OPC_UNKNOWN;
         addr  <= '0;
      end else if (cs_l) begin
         state <= ST_OPCODE;          // Frame over
      end else if (rx_done) begin
         case (state)
            ST_OPCODE: begin
               case (rx_byte)
                  `OP_WRITE: begin
                     op    <= OPC_WRITE;
                     state <= ST_ADDR;
                  end
                  `OP_READ: begin
                     op    <= OPC_READ;
                     state <= ST_ADDR;
                  end
                  default: begin
                     op    <= OPC_UNKNOWN;
                     state <= ST_IGNORE;   // Rest of frame skipped
                  end
               endcase
            end
            ST_ADDR: begin
               if (op == OPC_READ) begin
                  addr  <= mem_addr_t'(rx_byte) + mem_addr_t'(1);  // Start fetched now
                  state <= ST_DUMMY;
               end else begin
                  addr  <= mem_addr_t'(rx_byte);
                  state <= ST_WRITE_DATA;
               end
            end
            ST_DUMMY: begin
               addr  <= addr + mem_addr_t'(1);
               state <= ST_READ_DATA;
            end
            ST_WRITE_DATA, ST_READ_DATA: begin
               addr <= addr + mem_addr_t'(1);   // Auto increment, natural wrap
            end
            default: begin
               state <= ST_IGNORE;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Request and credits
   ////////////////////////////////////////

   // Held back while the memory queue is full
   assign issue = req_pend && (credits != '0);

   always_ff @(posedge spi_sck or negedge rst_n) begin
      if (!rst_n) begin
         req_pend <= 1'b0;
      end else if (rx_done && new_req) begin
         req_pend <= 1'b1;
      end else if (issue) begin
         req_pend <= 1'b0;
      end
   end

   always_ff @(posedge spi_sck) begin
      if (rx_done && new_req) begin
         req_write_q <= (state == ST_WRITE_DATA);
         req_addr_q  <= (state == ST_ADDR) ? mem_addr_t'(rx_byte) : addr;
         req_wdata_q <= mem_data_t'(rx_byte);   // Only used by stores
      end
   end

   always_ff @(posedge spi_sck or negedge rst_n) begin
      if (!rst_n) begin
         credits <= credit_t'(`MEM_CREDITS);
      end else begin
         credits <= credits - credit_t'(issue) + credit_t'(mem.credit_return);
      end
   end

   assign mem.req_valid = issue;
   assign mem.req_write = req_write_q;
   assign mem.req_addr  = req_addr_q;
   assign mem.req_wdata = req_wdata_q;

   ////////////////////////////////////////
   // Read buffer
   ////////////////////////////////////////

   always_ff @(posedge spi_sck or negedge rst_n) begin
      if (!rst_n) begin
         rd_buf_valid <= 1'b0;
      end else if (cs_l) begin
         rd_buf_valid <= 1'b0;
      end else if (mem.rsp_valid && reading) begin
         rd_buf_valid <= 1'b1;
      end else if (rx_done && reading) begin
         rd_buf_valid <= 1'b0;        // Handed to the shifter
      end
   end

   always_ff @(posedge spi_sck) begin
      if (mem.rsp_valid) begin
         rd_buf <= byte_t'(mem.rsp_rdata);
      end
   end

   // Shifter takes it at the next byte boundary
   assign tx_byte = rd_buf;
   assign tx_load = rd_buf_valid && reading;

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Memory never returns more credits than were handed out
   a_credit_max: assert property (@(posedge spi_sck) disable iff (!rst_n)
      credits <= credit_t'(`MEM_CREDITS));

   // Last credit gone, so the bus stays quiet until one comes back
   a_no_req_at_zero: assert property (@(posedge spi_sck) disable iff (!rst_n)
      (issue && (credits == credit_t'(1)) && !mem.credit_return) |=> !mem.req_valid);

endmodule

`default_nettype wire

// ==== source/spi_link_pkg.sv ====
`default_nettype none

`include "spi_bridge_config.svh"

package spi_link_pkg;

   // One byte on MOSI or MISO
   typedef logic [7:0] byte_t;

   // Frame opcode as decoded from byte 0
   typedef enum byte_t {
      OPC_WRITE   = `OP_WRITE,
      OPC_READ    = `OP_READ,
      OPC_UNKNOWN = 8'hFF       // Anything else, frame is dropped
   } opcode_e;

   // Position inside a frame while cs_l is low
   typedef enum logic [2:0] {
      ST_OPCODE,                // Waiting for byte 0
      ST_ADDR,                  // Byte 1, start address
      ST_DUMMY,                 // Read turnaround byte
      ST_WRITE_DATA,            // Every byte goes to memory
      ST_READ_DATA,             // Every byte period shifts a memory byte out
      ST_IGNORE                 // Bad opcode, wait for cs_l high
   } frame_state_e;

endpackage

`default_nettype wire

// ==== source/spi_shift_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_shift_unit import spi_link_pkg::*; (
   input  wire        spi_sck,
   input  wire        rst_n,
   input  wire        cs_l,
   input  wire        mosi,
   output logic       miso,
   output byte_t      rx_byte,
   output logic       rx_done,
   input  wire byte_t tx_byte,
   input  wire        tx_load
);

   logic [2:0] bit_cnt;    // Bits already taken in this byte
   byte_t      rx_shift;   // MOSI history, MSB first
   byte_t      tx_shift;   // Top bit is on MISO

   ////////////////////////////////////////
   // Receive
   ////////////////////////////////////////

   // Eighth bit is sampled on this edge
   assign rx_done = !cs_l && (bit_cnt == 3'd7);

   // Last bit joins straight from the pin
   assign rx_byte = {rx_shift[6:0], mosi};

   always_ff @(posedge spi_sck or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt <= '0;
      end else if (cs_l) begin
         bit_cnt <= '0;               // Partial byte is dropped
      end else begin
         bit_cnt <= bit_cnt + 3'd1;   // Wraps to 0 after bit 7
      end
   end

   always_ff @(posedge spi_sck) begin
      rx_shift <= {rx_shift[6:0], mosi};
   end

   ////////////////////////////////////////
   // Transmit
   ////////////////////////////////////////

   always_ff @(posedge spi_sck or negedge rst_n) begin
      if (!rst_n) begin
         tx_shift <= '0;
      end else if (cs_l) begin
         tx_shift <= '0;               // Idle line low
      end else if (rx_done) begin
         // Byte boundary, next byte period starts
         if (tx_load) begin
            tx_shift <= tx_byte;
         end else begin
            tx_shift <= '0;            // Nothing ready, send zeros
         end
      end else begin
         tx_shift <= {tx_shift[6:0], 1'b0};
      end
   end

   assign miso = tx_shift[7];

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Deselect kills the byte now and on the edge after
   a_no_done_deselected: assert property (@(posedge spi_sck) disable iff (!rst_n)
      cs_l |-> !rx_done ##1 !rx_done);

endmodule

`default_nettype wire

// ==== testbench/tb_spi_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_config.svh"

module tb_spi_bridge;

   localparam int SEED         = 58;
   localparam int RESET_CYCLES = 16;
   localparam int LED_CYCLES   = 60;     // 48 idle, 4 selected, 8 idle
   localparam int IDLE_CYCLES  = 4;      // Deselect gap per frame
   localparam int NUM_FRAMES   = 10;
   // Single, burst, wrap, bad frames
   localparam int FRAME_BITS   = 56 + 296 + 136 + 171;
   localparam int TIMEOUT_CYCLES =
      2 * (RESET_CYCLES + LED_CYCLES + FRAME_BITS + NUM_FRAMES * IDLE_CYCLES);

   logic       spi_sck;
   logic       pll_locked;
   logic       cs_l;
   logic       mosi;
   wire        miso;
   wire  [1:0] led;

   logic [7:0] ref_mem [256];   // Expected scratch contents
   logic [7:0] wr_data [$];     // Payload for the next write frame
   logic [`LED_CNT_BITS-1:0] led_model;
   int         cycle_cnt;
   int         error_count;

   spi_bridge_top u_spi_bridge_top (
      .spi_sck    (spi_sck),
      .pll_locked (pll_locked),
      .cs_l       (cs_l),
      .mosi       (mosi),
      .miso       (miso),
      .led        (led)
   );

   always #2 spi_sck = ~spi_sck;   // 4 ns period

   ////////////////////////////////////////
   // Checks and run limit
   ////////////////////////////////////////

   task automatic verify_byte(input string test_name, input logic [7:0] expected,
                              input logic [7:0] actual);
      assert (actual == expected) else begin
         error_count++;
         $display("** Error %s: expected 0x%02h, actual 0x%02h", test_name, expected, actual);
         $display("ERRORS FOUND");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   always @(posedge spi_sck) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("ERRORS FOUND");
         $fatal(1, "Run limit reached");
      end
   end

   ////////////////////////////////////////
   // Serial frame helpers
   ////////////////////////////////////////

   // MSB first, first bit of a frame also drops the select
   task automatic send_byte(input logic [7:0] value, input int nbits);
      for (int i = 7; i > 7 - nbits; i--) begin
         @(negedge spi_sck);
         cs_l = 1'b0;
         mosi = value[i];
      end
   endtask

   task automatic receive_byte(output logic [7:0] value);
      for (int i = 7; i >= 0; i--) begin
         @(negedge spi_sck);
         value[i] = miso;     // Stable since the rising edge
         mosi     = 1'b0;
      end
   endtask

   task automatic end_frame();
      @(negedge spi_sck);
      cs_l = 1'b1;
      mosi = 1'b0;
      repeat (IDLE_CYCLES - 1) @(negedge spi_sck);
   endtask

   // Stores wr_data from start on, cut_bits > 0 adds a broken trailing byte
   task automatic frame_write(input logic [7:0] start, input int cut_bits);
      logic [7:0] addr;
      addr = start;
      send_byte(`OP_WRITE, 8);
      send_byte(start, 8);
      foreach (wr_data[i]) begin
         send_byte(wr_data[i], 8);
         ref_mem[addr] = wr_data[i];
         addr++;                   // 255 wraps to 0
      end
      if (cut_bits > 0) begin
         send_byte(8'hA5, cut_bits);   // Never stored
      end
      end_frame();
   endtask

   task automatic frame_read(input logic [7:0] start, input int count,
                             input string test_name);
      logic [7:0] addr;
      logic [7:0] got;
      addr = start;
      send_byte(`OP_READ, 8);
      send_byte(start, 8);
      send_byte(8'h00, 8);         // Dummy
      repeat (count) begin
         receive_byte(got);
         verify_byte(test_name, ref_mem[addr], got);
         addr++;
      end
      end_frame();
   endtask

   // One clock of the LED test, sel is cs_l for the next edge
   task automatic led_step(input logic sel);
      @(negedge spi_sck);
      verify_byte("reset_led", {6'b0, led_model[`LED_CNT_BITS-1] & cs_l, 1'b0}, {6'b0, led});
      cs_l = sel;
      if (sel) begin
         led_model++;
      end
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic reset_and_led_test();
      repeat (RESET_CYCLES) begin
         @(negedge spi_sck);
         verify_byte("reset_miso", 8'h00, {7'b0, miso});
         verify_byte("reset_led", 8'h00, {6'b0, led});
      end
      pll_locked = 1'b1;          // Next rising edge releases reset
      led_model  = '0;
      repeat (48) led_step(1'b1);
      repeat (4) led_step(1'b0);  // Frame without bytes
      repeat (8) led_step(1'b1);
   endtask

   task automatic single_write_read_test();
      logic [7:0] addr;
      addr = 8'($urandom_range(0, 255));
      wr_data = {8'($urandom)};
      frame_write(addr, 0);
      frame_read(addr, 1, "single");
   endtask

   task automatic burst_test();
      logic [7:0] addr;
      addr = 8'($urandom_range(0, 255));
      wr_data = {};
      repeat (16) wr_data.push_back(8'($urandom));
      frame_write(addr, 0);
      frame_read(addr, 16, "burst");
   endtask

   task automatic wrap_test();
      wr_data = {};
      repeat (6) wr_data.push_back(8'($urandom));
      frame_write(8'd254, 0);     // 254, 255, 0 .. 3
      frame_read(8'd254, 6, "wrap");
   endtask

   task automatic bad_frame_test();
      logic [7:0] base;
      base = 8'($urandom_range(0, 255));
      wr_data = {};
      repeat (4) wr_data.push_back(8'($urandom));
      frame_write(base, 0);
      // Unknown opcode, payload must be dropped
      send_byte(8'h55, 8);
      send_byte(base, 8);
      send_byte(~ref_mem[base], 8);
      send_byte(~ref_mem[8'(base + 1)], 8);
      end_frame();
      // Two whole bytes then three bits of a third
      wr_data = {8'($urandom), 8'($urandom)};
      frame_write(8'(base + 1), 3);
      frame_read(base, 4, "bad_frame");
   endtask

   ////////////////////////////////////////
   // Sequence
   ////////////////////////////////////////

   initial begin
      spi_sck     = 1'b0;
      pll_locked  = 1'b0;
      cs_l        = 1'b1;
      mosi        = 1'b0;
      cycle_cnt   = 0;
      error_count = 0;
      void'($urandom(SEED));

      reset_and_led_test();
      single_write_read_test();
      burst_test();
      wrap_test();
      bad_frame_test();

      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire
